/* logic/adc_convert_ctrl.sv */
module adc_convert_ctrl (
  input logic clk,
  input logic reset,
  conv_cmd_if.sink cmd,
  conv_res_if.source res,
  output logic adc_start,
  output adc_pkg::chan_t adc_chnum,
  input logic adc_calibrate,
  input logic adc_datavalid,
  input adc_pkg::sample_t adc_result
);

  adc_pkg::conv_state_t state;
  adc_pkg::chan_t cur_chan;
  adc_pkg::chan_t last_chan;
  logic take;
  logic got_result;
  logic last_hit;

  assign take = cmd.cmd_valid & cmd.cmd_ready & (state == adc_pkg::st_idle);
  assign got_result = (state == adc_pkg::st_wait_high) & adc_datavalid;
  assign last_hit = (cur_chan == last_chan);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= adc_pkg::st_idle;
      cmd.cmd_ready <= 1'b0;
      cmd.busy <= 1'b0;
      adc_start <= 1'b0;
      adc_chnum <= '0;
      res.res_wr <= 1'b0;
      res.scan_done <= 1'b0;
    end else begin
      res.res_wr <= 1'b0;
      res.scan_done <= 1'b0;
      case (state)
        adc_pkg::st_idle: begin
          if (take) begin
            cmd.cmd_ready <= 1'b0;
            cmd.busy <= 1'b1;
            state <= adc_pkg::st_arm;
          end else begin
            cmd.cmd_ready <= 1'b1;
          end
        end
        adc_pkg::st_arm: begin
          adc_chnum <= cur_chan;
          if (!adc_calibrate) begin // hold off while calibrating
            adc_start <= 1'b1;
            state <= adc_pkg::st_wait_low;
          end
        end
        adc_pkg::st_wait_low: begin
          if (!adc_datavalid) begin
            state <= adc_pkg::st_wait_high;
          end
        end
        adc_pkg::st_wait_high: begin
          if (adc_datavalid) begin // fresh result after the low phase
            adc_start <= 1'b0;
            res.res_wr <= 1'b1;
            if (last_hit) begin
              res.scan_done <= 1'b1;
              cmd.busy <= 1'b0;
              cmd.cmd_ready <= 1'b1;
              state <= adc_pkg::st_idle;
            end else begin
              state <= adc_pkg::st_next;
            end
          end
        end
        adc_pkg::st_next: begin
          state <= adc_pkg::st_arm; // write of previous result overlaps
        end
        default: begin
          state <= adc_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cur_chan <= cmd.first;
      last_chan <= cmd.last;
    end else if (state == adc_pkg::st_next) begin
      cur_chan <= cur_chan + 1'b1; // wraps past the top channel
    end
    if (got_result) begin
      res.res_chan <= cur_chan;
      res.res_data <= adc_result;
    end
  end

endmodule

/* logic/adc_if.sv */
interface conv_cmd_if;
  logic cmd_valid;
  logic cmd_ready;
  logic busy;
  adc_pkg::chan_t first;
  adc_pkg::chan_t last;

  modport source (
    output cmd_valid, first, last,
    input cmd_ready, busy
  );

  modport sink (
    input cmd_valid, first, last,
    output cmd_ready, busy
  );
endinterface

interface conv_res_if;
  logic res_wr;
  adc_pkg::chan_t res_chan;
  adc_pkg::sample_t res_data;
  logic scan_done; // pulses with the last write

  modport source (
    output res_wr, res_chan, res_data, scan_done
  );

  modport sink (
    input res_wr, res_chan, res_data, scan_done
  );
endinterface

/* logic/adc_pkg.sv */
`include "adc_settings.svh"

package adc_pkg;

  typedef logic [`ADC_CH_W-1:0] chan_t;
  typedef logic [`ADC_RES_W-1:0] sample_t;

  // control word, mode 0: one conversion
  typedef struct packed {
    logic mode;
    logic [30-`ADC_CH_W:0] rsvd;
    chan_t chan;
  } single_cmd_t;

  // control word, mode 1: walk first..last
  typedef struct packed {
    logic mode;
    logic [30-2*`ADC_CH_W:0] rsvd;
    chan_t first;
    chan_t last;
  } scan_cmd_t;

  // mode sits in bit 31 of both views
  typedef union packed {
    single_cmd_t single_view;
    scan_cmd_t scan_view;
  } adc_cmd_u;

  typedef enum logic [2:0] {
    st_idle,
    st_arm,
    st_wait_low,
    st_wait_high,
    st_next
  } conv_state_t;

endpackage

/* logic/adc_reg_decode.sv */
`include "adc_settings.svh"

module adc_reg_decode (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [`ADC_APB_AW-1:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  conv_cmd_if.source cmd,
  output adc_pkg::chan_t rd_chan,
  output logic rd_strobe,
  input adc_pkg::sample_t rd_data,
  input logic [31:0] valid_mask,
  input logic done,
  output logic done_clr
);

  logic access;
  logic is_ctrl;
  logic is_status;
  logic is_valid;
  logic is_result;
  logic mapped;
  logic ctrl_busy;
  logic ctrl_wr;
  adc_pkg::adc_cmd_u cmd_word;

  assign access = psel & penable;

  assign is_ctrl = (paddr == `ADC_REG_CTRL);
  assign is_status = (paddr == `ADC_REG_STATUS);
  assign is_valid = (paddr == `ADC_REG_VALID);
  assign is_result = (paddr >= `ADC_REG_RESULT_BASE) && (paddr[1:0] == 2'b00);
  assign mapped = is_ctrl | is_status | is_valid | is_result;

  // running or still waiting for the handshake
  assign ctrl_busy = cmd.busy | cmd.cmd_valid;

  assign pready = 1'b1;
  assign pslverr = access & (~mapped | (pwrite & is_ctrl & ctrl_busy));

  assign ctrl_wr = access & pwrite & is_ctrl & ~ctrl_busy;
  assign cmd_word = pwdata;

  // result window index
  assign rd_chan = paddr[`ADC_CH_W+1:2];
  assign rd_strobe = access & ~pwrite & is_result;
  assign done_clr = access & ~pwrite & is_status;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.cmd_valid <= 1'b0;
    end else if (ctrl_wr) begin
      cmd.cmd_valid <= 1'b1;
    end else if (cmd.cmd_ready) begin
      cmd.cmd_valid <= 1'b0; // taken by the controller
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_wr) begin
      if (cmd_word.scan_view.mode) begin
        cmd.first <= cmd_word.scan_view.first;
        cmd.last <= cmd_word.scan_view.last;
      end else begin
        cmd.first <= cmd_word.single_view.chan; // single is a scan of one
        cmd.last <= cmd_word.single_view.chan;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (is_status) begin
      prdata[1:0] = {done, ctrl_busy};
    end else if (is_valid) begin
      prdata = valid_mask;
    end else if (is_result) begin
      prdata[`ADC_RES_W-1:0] = rd_data;
    end
  end

endmodule

/* logic/adc_result_bank.sv */
`include "adc_settings.svh"

module adc_result_bank (
  input logic clk,
  input logic reset,
  conv_res_if.sink res,
  input adc_pkg::chan_t rd_chan,
  input logic rd_strobe,
  output adc_pkg::sample_t rd_data,
  output logic [31:0] valid_mask,
  output logic done,
  input logic done_clr
);

  adc_pkg::sample_t samples [0:(1<<`ADC_CH_W)-1];
  logic [31:0] valid;

  always_ff @(posedge clk) begin
    if (res.res_wr) begin
      samples[res.res_chan] <= res.res_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (rd_strobe) begin
        valid[rd_chan] <= 1'b0;
      end
      if (res.res_wr) begin
        valid[res.res_chan] <= 1'b1; // write beats a same-cycle read
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (res.scan_done) begin
      done <= 1'b1;
    end else if (done_clr) begin
      done <= 1'b0;
    end
  end

  // read path is combinational for the apb access phase
  assign rd_data = samples[rd_chan];
  assign valid_mask = valid;

endmodule

/* logic/adc_settings.svh */
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

// converter geometry
`define ADC_CH_W 5
`define ADC_RES_W 12

// apb address width in bits
`define ADC_APB_AW 8

// register byte offsets
`define ADC_REG_CTRL 8'h00
`define ADC_REG_STATUS 8'h04
`define ADC_REG_VALID 8'h08
`define ADC_REG_RESULT_BASE 8'h80 // result n at base + 4*n

`endif

/* logic/adc_subsystem.sv */
`include "adc_settings.svh"

module adc_subsystem (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [`ADC_APB_AW-1:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic adc_start,
  output adc_pkg::chan_t adc_chnum,
  input logic adc_calibrate,
  input logic adc_datavalid,
  input adc_pkg::sample_t adc_result
);

  adc_pkg::chan_t rd_chan;
  logic rd_strobe;
  adc_pkg::sample_t rd_data;
  logic [31:0] valid_mask;
  logic done;
  logic done_clr;

  conv_cmd_if cmd_bus ();
  conv_res_if res_bus ();

  adc_reg_decode i_decode (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .cmd(cmd_bus.source),
    .rd_chan(rd_chan),
    .rd_strobe(rd_strobe),
    .rd_data(rd_data),
    .valid_mask(valid_mask),
    .done(done),
    .done_clr(done_clr)
  );

  adc_convert_ctrl i_execute (
    .clk(clk),
    .reset(reset),
    .cmd(cmd_bus.sink),
    .res(res_bus.source),
    .adc_start(adc_start),
    .adc_chnum(adc_chnum),
    .adc_calibrate(adc_calibrate),
    .adc_datavalid(adc_datavalid),
    .adc_result(adc_result)
  );

  adc_result_bank i_result (
    .clk(clk),
    .reset(reset),
    .res(res_bus.sink),
    .rd_chan(rd_chan),
    .rd_strobe(rd_strobe),
    .rd_data(rd_data),
    .valid_mask(valid_mask),
    .done(done),
    .done_clr(done_clr)
  );

endmodule

/* sim/adc_model.sv */
`include "adc_settings.svh"

module adc_model (
  input logic clk,
  input logic reset,
  input logic adc_start,
  input adc_pkg::chan_t adc_chnum,
  input logic cal_req,
  output logic adc_calibrate,
  output logic adc_datavalid,
  output adc_pkg::sample_t adc_result
);

  localparam logic [31:0] seed = 32'hb0eb_fa26;
  localparam int cal_cycles = 20;

  adc_pkg::sample_t last_result [0:(1<<`ADC_CH_W)-1]; // last value per channel
  logic [31:0] lcg_state;
  logic converting;
  logic presenting;
  adc_pkg::chan_t conv_chan;
  adc_pkg::sample_t conv_value;
  int conv_left;
  int cal_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    adc_calibrate = 1'b0;
    adc_datavalid = 1'b1;
    adc_result = '0;
  end

  always @(posedge clk) begin : converter
    logic [31:0] draw;
    if (reset) begin
      lcg_state <= seed;
      converting <= 1'b0;
      presenting <= 1'b0;
      adc_datavalid <= 1'b1;
    end else if (converting) begin
      if (conv_left > 1) begin
        conv_left <= conv_left - 1;
      end else begin
        adc_result <= conv_value;
        adc_datavalid <= 1'b1;
        last_result[conv_chan] <= conv_value;
        converting <= 1'b0;
        presenting <= 1'b1;
      end
    end else if (presenting) begin
      if (!adc_start) begin
        presenting <= 1'b0; // controller took the result
      end
    end else if (adc_start) begin
      draw = lcg_next(lcg_state);
      lcg_state <= draw;
      conv_left <= 3 + int'(draw[10:8]); // 3..10 cycles
      conv_value <= draw[27:16];
      conv_chan <= adc_chnum;
      adc_datavalid <= 1'b0;
      converting <= 1'b1;
    end
  end

  always @(posedge clk) begin : calibration
    if (reset) begin
      adc_calibrate <= 1'b0;
      cal_left <= 0;
    end else if (cal_req) begin
      adc_calibrate <= 1'b1;
      cal_left <= cal_cycles - 1;
    end else if (cal_left != 0) begin
      cal_left <= cal_left - 1;
    end else begin
      adc_calibrate <= 1'b0;
    end
  end

endmodule

/* sim/adc_subsystem_props.sv */
module adc_subsystem_props (
  input logic clk,
  input logic reset,
  input logic adc_start,
  input logic adc_calibrate,
  input logic adc_datavalid,
  input logic res_wr,
  input logic penable,
  input logic pslverr
);

  int unsigned assert_fails = 0;

  start_holdoff: assert property (@(posedge clk) disable iff (reset)
    $rose(adc_start) |-> !$past(adc_calibrate))
    else begin
      $error("adc_start rose while adc_calibrate was high");
      assert_fails++;
    end

  // a write takes a fresh datavalid rise
  result_on_valid: assert property (@(posedge clk) disable iff (reset)
    res_wr |-> $past(adc_datavalid) && !$past(adc_datavalid, 2))
    else begin
      $error("res_wr without a fresh low-to-high adc_datavalid");
      assert_fails++;
    end

  error_in_access: assert property (@(posedge clk) disable iff (reset)
    pslverr |-> penable)
    else begin
      $error("pslverr raised outside the access phase");
      assert_fails++;
    end

endmodule

bind adc_subsystem adc_subsystem_props i_props (
  .clk(clk),
  .reset(reset),
  .adc_start(adc_start),
  .adc_calibrate(adc_calibrate),
  .adc_datavalid(adc_datavalid),
  .res_wr(res_bus.res_wr),
  .penable(penable),
  .pslverr(pslverr)
);

/* sim/adc_subsystem_tb.sv */
`include "adc_settings.svh"

module adc_subsystem_tb;

  // two full 32-channel scans at 10 cycles each plus calibrate gaps
  localparam int max_cycles = 4000;

  logic clk;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`ADC_APB_AW-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic adc_start;
  adc_pkg::chan_t adc_chnum;
  logic adc_calibrate;
  logic adc_datavalid;
  adc_pkg::sample_t adc_result;
  logic cal_req;
  int pass_count = 0;
  int fail_count = 0;
  int cycles = 0;
  logic [31:0] exp_valid = '0; // follows writes and read clears

  adc_subsystem i_dut (.*);
  adc_model i_model (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", max_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      fail_count++;
    end
  endtask

  task automatic check_sample(input string name, input adc_pkg::sample_t got,
                              input adc_pkg::sample_t exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      fail_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
      fail_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("t=%0t %s", $time, msg);
    fail_count++;
  endtask

  task automatic report_test(input string name, input int f0);
    if (fail_count == f0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, fail_count - f0);
    end
  endtask

  function automatic logic [`ADC_APB_AW-1:0] result_addr(input int c);
    return `ADC_APB_AW'(`ADC_REG_RESULT_BASE + 4 * c);
  endfunction

  task automatic apb_access(input logic wr, input logic [`ADC_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk); // access phase settled
    rdata = prdata;
    err = pslverr;
    check_flag("pready", pready, 1'b1);
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input logic [`ADC_APB_AW-1:0] addr, input string name,
                            input logic [31:0] exp);
    logic [31:0] rd;
    logic err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    check_word(name, rd, exp);
    check_flag("pslverr", err, 1'b0);
  endtask

  task automatic write_ctrl(input logic [31:0] word, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_access(1'b1, `ADC_REG_CTRL, word, rd, err);
    check_flag("pslverr", err, exp_err);
  endtask

  // poll until idle, then one more read so done is both seen and cleared
  task automatic wait_idle();
    logic [31:0] st;
    logic err;
    int seen;
    seen = 0;
    do begin
      apb_access(1'b0, `ADC_REG_STATUS, 32'h0, st, err);
      seen += st[1];
    end while (st[0]);
    apb_access(1'b0, `ADC_REG_STATUS, 32'h0, st, err);
    seen += st[1];
    if (seen != 1) note_failure($sformatf("status done seen %0d times, expected once", seen));
  endtask

  task automatic mark_written(input int first, input int last);
    for (int c = first; c <= last; c++) begin
      exp_valid[c] = 1'b1;
    end
  endtask

  task automatic check_results(input int first, input int last);
    logic [31:0] rd;
    logic err;
    for (int c = first; c <= last; c++) begin
      apb_access(1'b0, result_addr(c), 32'h0, rd, err);
      check_sample($sformatf("result[%0d]", c), rd[`ADC_RES_W-1:0], i_model.last_result[c]);
      check_flag("pslverr", err, 1'b0);
      exp_valid[c] = 1'b0;
    end
  endtask

  task automatic test_reset_state();
    int f0;
    f0 = fail_count;
    @(negedge clk);
    check_flag("pslverr", pslverr, 1'b0);
    read_check(`ADC_REG_STATUS, "status", 32'h0);
    read_check(`ADC_REG_VALID, "valid", 32'h0);
    report_test("reset state", f0);
  endtask

  task automatic test_single();
    int f0;
    f0 = fail_count;
    write_ctrl(32'h0000_0005, 1'b0); // mode 0, channel 5
    wait_idle();
    mark_written(5, 5);
    read_check(`ADC_REG_VALID, "valid", 32'h0000_0020);
    check_results(5, 5);
    report_test("single conversion", f0);
  endtask

  task automatic test_read_clear();
    int f0;
    f0 = fail_count;
    read_check(`ADC_REG_VALID, "valid", exp_valid);
    check_results(5, 5); // sample survives the clear
    report_test("read clear", f0);
  endtask

  task automatic test_scan();
    int f0;
    f0 = fail_count;
    write_ctrl({1'b1, 21'h0, 5'd3, 5'd9}, 1'b0); // mode 1, first 3, last 9
    wait_idle();
    mark_written(3, 9);
    read_check(`ADC_REG_VALID, "valid", exp_valid);
    check_results(3, 9);
    read_check(`ADC_REG_STATUS, "status", 32'h0);
    read_check(`ADC_REG_VALID, "valid", exp_valid);
    report_test("scan", f0);
  endtask

  task automatic test_calibrate();
    int f0;
    int held;
    f0 = fail_count;
    held = 0;
    @(posedge clk);
    cal_req <= 1'b1;
    @(posedge clk);
    cal_req <= 1'b0;
    write_ctrl(32'h0000_000c, 1'b0); // channel 12
    @(negedge clk);
    while (adc_calibrate) begin
      check_flag("adc_start", adc_start, 1'b0);
      held++;
      @(negedge clk);
    end
    if (held == 0) note_failure("calibrate ended before the command was under way");
    wait_idle();
    mark_written(12, 12);
    read_check(`ADC_REG_VALID, "valid", exp_valid);
    check_results(12, 12);
    report_test("calibrate hold-off", f0);
  endtask

  task automatic test_errors();
    logic [31:0] rd;
    logic err;
    int f0;
    f0 = fail_count;
    write_ctrl({1'b1, 21'h0, 5'd0, 5'd15}, 1'b0);
    write_ctrl(32'h0000_0014, 1'b1); // channel 20, refused while busy
    wait_idle();
    mark_written(0, 15);
    read_check(`ADC_REG_VALID, "valid", exp_valid);
    check_results(0, 15);
    apb_access(1'b0, 8'h40, 32'h0, rd, err);
    check_flag("pslverr", err, 1'b1);
    report_test("errors", f0);
  endtask

  initial begin
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cal_req = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_single();
    test_read_clear();
    test_scan();
    test_calibrate();
    test_errors();
    if (i_dut.i_props.assert_fails != 0) begin
      note_failure($sformatf("%0d bound assertion failures", i_dut.i_props.assert_fails));
    end
    $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+logic
logic/adc_pkg.sv
logic/adc_if.sv
logic/adc_reg_decode.sv
logic/adc_convert_ctrl.sv
logic/adc_result_bank.sv
logic/adc_subsystem.sv
sim/adc_model.sv
sim/adc_subsystem_props.sv
sim/adc_subsystem_tb.sv
